/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Numeric values are shared with the stimulus file
    typedef enum logic [5:0] {
        ILLEGAL = 6'd0,
        LUI     = 6'd1,
        AUIPC   = 6'd2,
        JAL     = 6'd3,
        JALR    = 6'd4,
        BEQ     = 6'd5,
        BNE     = 6'd6,
        BLT     = 6'd7,
        BGE     = 6'd8,
        BLTU    = 6'd9,
        BGEU    = 6'd10,
        LB      = 6'd11,
        LH      = 6'd12,
        LW      = 6'd13,
        LBU     = 6'd14,
        LHU     = 6'd15,
        SB      = 6'd16,
        SH      = 6'd17,
        SW      = 6'd18,
        ADDI    = 6'd19,
        SLTI    = 6'd20,
        SLTIU   = 6'd21,
        XORI    = 6'd22,
        ORI     = 6'd23,
        ANDI    = 6'd24,
        SLLI    = 6'd25,
        SRLI    = 6'd26,
        SRAI    = 6'd27,
        ADD     = 6'd28,
        SUB     = 6'd29,
        SLL     = 6'd30,
        SLT     = 6'd31,
        SLTU    = 6'd32,
        XOR     = 6'd33,
        SRL     = 6'd34,
        SRA     = 6'd35,
        OR      = 6'd36,
        AND     = 6'd37
    } inst_op_t;

    typedef struct packed {
        xlen_t inst;
        xlen_t inst_addr;
        logic  jump_pred;
    } fetch_pkt_t;

    typedef struct packed {
        inst_op_t op;
        logic     jump_pred;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        xlen_t    inst_addr;
        logic     c_extension;
    } dec_inst_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd1;
    localparam reg_idx_t REG_SP   = 5'd2;

    localparam logic [1:0] RVC_REG_BASE = 2'b01; // x8 to x15

endpackage

/* source/rv32_base_decoder.sv */
module rv32_base_decoder (
    input  rv_decode_pkg::xlen_t     inst,
    output rv_decode_pkg::dec_inst_t dec
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       is_shift_imm;
    inst_op_t   op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm;

    assign opcode       = inst[6:0];
    assign funct3       = inst[14:12];
    assign alt          = inst[30]; // SUB, SRA, SRAI
    assign is_shift_imm = (opcode == OPC_OP_IMM) && (funct3[1:0] == 2'b01);

    always_comb begin
        op = ILLEGAL;
        case (opcode)
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = (funct3 == 3'b000) ? JALR : ILLEGAL;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = ADDI;
                    3'b001: op = SLLI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b101: op = alt ? SRAI : SRLI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    3'b000: op = alt ? SUB : ADD;
                    3'b001: op = SLL;
                    3'b010: op = SLT;
                    3'b011: op = SLTU;
                    3'b100: op = XOR;
                    3'b101: op = alt ? SRA : SRL;
                    3'b110: op = OR;
                    3'b111: op = AND;
                endcase
            end
            default: op = ILLEGAL;
        endcase
    end

    // Operand fields by format
    always_comb begin
        rd  = REG_ZERO;
        rs1 = REG_ZERO;
        rs2 = REG_ZERO;
        imm = '0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                rd  = inst[11:7];
                imm = {inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                rd  = inst[11:7];
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                rs1 = inst[19:15];
                rs2 = inst[24:20];
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_STORE: begin
                rs1 = inst[19:15];
                rs2 = inst[24:20];
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            OPC_OP: begin
                rd  = inst[11:7];
                rs1 = inst[19:15];
                rs2 = inst[24:20];
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                rd  = inst[11:7];
                rs1 = inst[19:15];
                imm = is_shift_imm ? {27'b0, inst[24:20]} : {{21{inst[31]}}, inst[30:20]};
            end
            default: ;
        endcase
    end

    always_comb begin
        dec    = '0;
        dec.op = op;
        if (op != ILLEGAL) begin
            dec.rd  = rd;
            dec.rs1 = rs1;
            dec.rs2 = rs2;
            dec.imm = imm;
        end
    end

endmodule

/* source/rvc_decoder.sv */
module rvc_decoder (
    input  logic [15:0]              inst,
    output rv_decode_pkg::dec_inst_t dec
);
    import rv_decode_pkg::*;

    logic [1:0] quadrant;
    logic [2:0] funct3;
    reg_idx_t   rd_full;
    reg_idx_t   rs2_full;
    reg_idx_t   creg_hi;
    reg_idx_t   creg_lo;
    xlen_t      imm_ci;
    xlen_t      imm_cj;
    xlen_t      imm_cb;
    xlen_t      imm_cls;
    xlen_t      imm_4spn;
    xlen_t      shamt;

    assign quadrant = inst[1:0];
    assign funct3   = inst[15:13];
    assign rd_full  = inst[11:7];
    assign rs2_full = inst[6:2];
    assign creg_hi  = {RVC_REG_BASE, inst[9:7]};
    assign creg_lo  = {RVC_REG_BASE, inst[4:2]};

    assign imm_ci   = {{27{inst[12]}}, inst[6:2]};
    assign imm_cj   = {{21{inst[12]}}, inst[8], inst[10:9], inst[6], inst[7], inst[2],
                       inst[11], inst[5:3], 1'b0};
    assign imm_cb   = {{24{inst[12]}}, inst[6:5], inst[2], inst[11:10], inst[4:3], 1'b0};
    assign imm_cls  = {25'b0, inst[5], inst[12:10], inst[6], 2'b00}; // C.LW, C.SW
    assign imm_4spn = {22'b0, inst[10:7], inst[12:11], inst[5], inst[6], 2'b00};
    assign shamt    = {26'b0, inst[12], inst[6:2]};

    always_comb begin
        dec = '0; // ILLEGAL unless a case below matches
        case (quadrant)
            2'b00: begin
                case (funct3)
                    3'b000: begin
                        if (imm_4spn != '0) begin // Zero imm covers the all-zero word
                            dec.op  = ADDI;
                            dec.rd  = creg_lo;
                            dec.rs1 = REG_SP;
                            dec.imm = imm_4spn;
                        end
                    end
                    3'b010: begin
                        dec.op  = LW;
                        dec.rd  = creg_lo;
                        dec.rs1 = creg_hi;
                        dec.imm = imm_cls;
                    end
                    3'b110: begin
                        dec.op  = SW;
                        dec.rs1 = creg_hi;
                        dec.rs2 = creg_lo;
                        dec.imm = imm_cls;
                    end
                    default: ;
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'b000, 3'b010: begin // C.ADDI, C.LI
                        dec.op  = ADDI;
                        dec.rd  = rd_full;
                        dec.rs1 = (funct3 == 3'b000) ? rd_full : REG_ZERO;
                        dec.imm = imm_ci;
                    end
                    3'b001, 3'b101: begin // C.JAL, C.J
                        dec.op  = JAL;
                        dec.rd  = (funct3 == 3'b001) ? REG_RA : REG_ZERO;
                        dec.imm = imm_cj;
                    end
                    3'b011: begin
                        if (rd_full == REG_SP) begin
                            dec.op  = ADDI;
                            dec.rd  = REG_SP;
                            dec.rs1 = REG_SP;
                            dec.imm = {{23{inst[12]}}, inst[4:3], inst[5], inst[2], inst[6], 4'b0};
                        end else begin
                            dec.op  = LUI;
                            dec.rd  = rd_full;
                            dec.imm = {{15{inst[12]}}, inst[6:2], 12'b0};
                        end
                    end
                    3'b100: begin
                        dec.rd  = creg_hi;
                        dec.rs1 = creg_hi;
                        case (inst[11:10])
                            2'b00: begin
                                dec.op  = SRLI;
                                dec.imm = shamt;
                            end
                            2'b01: begin
                                dec.op  = SRAI;
                                dec.imm = shamt;
                            end
                            2'b10: begin
                                dec.op  = ANDI;
                                dec.imm = imm_ci;
                            end
                            2'b11: begin
                                dec.rs2 = creg_lo;
                                case (inst[6:5])
                                    2'b00: dec.op = SUB;
                                    2'b01: dec.op = XOR;
                                    2'b10: dec.op = OR;
                                    2'b11: dec.op = AND;
                                endcase
                                if (inst[12]) begin
                                    dec = '0; // RV64 only
                                end
                            end
                        endcase
                    end
                    3'b110, 3'b111: begin
                        dec.op  = (funct3 == 3'b110) ? BEQ : BNE;
                        dec.rs1 = creg_hi;
                        dec.rs2 = REG_ZERO;
                        dec.imm = imm_cb;
                    end
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: begin
                        dec.op  = SLLI;
                        dec.rd  = rd_full;
                        dec.rs1 = rd_full;
                        dec.imm = shamt;
                    end
                    3'b010: begin
                        dec.op  = LW;
                        dec.rd  = rd_full;
                        dec.rs1 = REG_SP;
                        dec.imm = {24'b0, inst[3:2], inst[12], inst[6:4], 2'b00};
                    end
                    3'b100: begin
                        if (rs2_full != REG_ZERO) begin // C.MV or C.ADD
                            dec.op  = ADD;
                            dec.rd  = rd_full;
                            dec.rs1 = inst[12] ? rd_full : REG_ZERO;
                            dec.rs2 = rs2_full;
                        end else if (rd_full != REG_ZERO) begin // C.JR or C.JALR
                            dec.op  = JALR;
                            dec.rd  = inst[12] ? REG_RA : REG_ZERO;
                            dec.rs1 = rd_full;
                        end
                    end
                    3'b110: begin
                        dec.op  = SW;
                        dec.rs1 = REG_SP;
                        dec.rs2 = rs2_full;
                        dec.imm = {24'b0, inst[8:7], inst[12:9], 2'b00};
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* source/decode_stage.sv */
module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      fet_ready,
    input  rv_decode_pkg::fetch_pkt_t fetch,
    input  logic                      lsb_full,
    input  logic                      rob_full,
    input  logic                      rs_full,
    output logic                      stall,
    output logic                      dec_ready,
    output rv_decode_pkg::dec_inst_t  dec
);
    import rv_decode_pkg::*;

    dec_inst_t base_dec;
    dec_inst_t rvc_dec;
    dec_inst_t next_dec;
    logic      is_c;
    logic      accept;

    rv32_base_decoder u_base_decoder (
        .inst (fetch.inst),
        .dec  (base_dec)
    );

    rvc_decoder u_rvc_decoder (
        .inst (fetch.inst[15:0]),
        .dec  (rvc_dec)
    );

    assign is_c   = (fetch.inst[1:0] != 2'b11);
    assign accept = fet_ready && !stall && !flush;

    always_comb begin
        next_dec             = is_c ? rvc_dec : base_dec;
        next_dec.inst_addr   = fetch.inst_addr;
        next_dec.jump_pred   = fetch.jump_pred;
        next_dec.c_extension = is_c;
    end

    // Which unit the held instruction needs at dispatch
    always_comb begin
        stall = 1'b0;
        if (dec_ready) begin
            case (dec.op)
                LUI, AUIPC, JAL: begin
                    stall = rob_full;
                end
                LB, LH, LW, LBU, LHU, SB, SH, SW: begin
                    stall = rob_full || lsb_full;
                end
                default: begin
                    stall = rob_full || rs_full;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_ready <= 1'b0;
            dec       <= '0;
        end else if (flush) begin
            dec_ready <= 1'b0; // Record left stale
        end else if (accept) begin
            dec_ready <= 1'b1;
            dec       <= next_dec;
        end else if (!stall) begin
            dec_ready <= 1'b0; // Bubble
        end
    end

endmodule

/* dv/decode_stage_checker.sv */
module decode_stage_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     flush,
    input logic                     stall,
    input logic                     dec_ready,
    input rv_decode_pkg::dec_inst_t dec
);
    import rv_decode_pkg::*;

    int fail_count = 0;

    // Output register is cleared while reset is held
    property p_reset_clears_ready;
        @(posedge clk) !rst_n |-> !dec_ready;
    endproperty

    // A stall is only raised for a held instruction
    property p_stall_needs_ready;
        @(posedge clk) disable iff (!rst_n)
            stall |-> dec_ready;
    endproperty

    property p_stall_holds_record;
        @(posedge clk) disable iff (!rst_n)
            (stall && !flush) |=> ($stable(dec) && $stable(dec_ready));
    endproperty

    a_reset_clears_ready: assert property (p_reset_clears_ready)
        else begin
            $error("dec_ready high during reset");
            fail_count++;
        end

    a_stall_needs_ready: assert property (p_stall_needs_ready)
        else begin
            $error("stall raised without dec_ready");
            fail_count++;
        end

    a_stall_holds_record: assert property (p_stall_holds_record)
        else begin
            $error("decoded record changed during stall");
            fail_count++;
        end

endmodule

/* dv/decode_stage_tb.sv */
module decode_stage_tb;
    import rv_decode_pkg::*;

    localparam int MAX_VEC    = 128;
    localparam int WAIT_LIMIT = 200;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       fet_ready;
    fetch_pkt_t fetch;
    logic       lsb_full;
    logic       rob_full;
    logic       rs_full;
    logic       stall;
    logic       dec_ready;
    dec_inst_t  dec;

    logic [31:0] vec_inst [MAX_VEC];
    logic [31:0] vec_addr [MAX_VEC];
    logic [31:0] vec_pred [MAX_VEC];
    logic [31:0] vec_op   [MAX_VEC];
    logic [31:0] vec_rd   [MAX_VEC];
    logic [31:0] vec_rs1  [MAX_VEC];
    logic [31:0] vec_rs2  [MAX_VEC];
    logic [31:0] vec_imm  [MAX_VEC];
    logic [31:0] vec_c    [MAX_VEC];
    int          num_vec;
    logic [15:0] lfsr;

    decode_stage DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .fet_ready (fet_ready),
        .fetch     (fetch),
        .lsb_full  (lsb_full),
        .rob_full  (rob_full),
        .rs_full   (rs_full),
        .stall     (stall),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    bind decode_stage decode_stage_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (DUT.u_checker.fail_count != 0) begin
            $display("An assertion in decode_stage_checker failed");
            $display("Testbench failed");
            $fatal(1, "Checker assertion");
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // ROB only for op numbers 1 to 3, ROB or LSB for 11 to 18
    function automatic logic expected_stall(input logic [5:0] op, input logic rob,
                                            input logic lsb, input logic rs);
        if (op >= 6'd1 && op <= 6'd3) begin
            return rob;
        end else if (op >= 6'd11 && op <= 6'd18) begin
            return rob || lsb;
        end
        return rob || rs;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out while %s", what);
        $display("Testbench failed");
        $fatal(1, "Timeout");
    endtask

    task automatic check_record(input int i);
        check_value("dec_ready", 32'(dec_ready), 32'd1);
        check_value("dec.op", 32'(dec.op), vec_op[i]);
        check_value("dec.rd", 32'(dec.rd), vec_rd[i]);
        check_value("dec.rs1", 32'(dec.rs1), vec_rs1[i]);
        check_value("dec.rs2", 32'(dec.rs2), vec_rs2[i]);
        check_value("dec.imm", dec.imm, vec_imm[i]);
        check_value("dec.inst_addr", dec.inst_addr, vec_addr[i]);
        check_value("dec.jump_pred", 32'(dec.jump_pred), vec_pred[i]);
        check_value("dec.c_extension", 32'(dec.c_extension), vec_c[i]);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("dv/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("Testbench failed");
            $fatal(1, "Missing stimulus");
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", vec_inst[num_vec],
                            vec_addr[num_vec], vec_pred[num_vec], vec_op[num_vec],
                            vec_rd[num_vec], vec_rs1[num_vec], vec_rs2[num_vec],
                            vec_imm[num_vec], vec_c[num_vec]);
                if (n == 9) begin
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        fet_ready <= 1'b1;
        fetch     <= {vec_inst[i], vec_addr[i], vec_pred[i][0]};
    endtask

    task automatic drive_random_full();
        lfsr = lfsr_step(lfsr);
        rob_full <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        lsb_full <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        rs_full <= lfsr[0];
    endtask

    initial begin
        int        idx;
        int        pending;
        int        stall_cycles;
        logic      prev_stall;
        logic      accepted_now;
        dec_inst_t prev_dec;

        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        fet_ready   = 1'b0;
        fetch       = '0;
        lsb_full    = 1'b0;
        rob_full    = 1'b0;
        rs_full     = 1'b0;
        lfsr        = 16'd32089;
        load_vectors();
        if (num_vec == 0) begin
            $display("The stimulus file holds no vectors");
            $display("Testbench failed");
            $fatal(1, "Empty stimulus");
        end
        repeat (3) @(posedge clk);
        check_value("dec_ready", 32'(dec_ready), 32'd0);
        rst_n <= 1'b1;

        // Decode of every vector, one at a time
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            drive_vector(i);
            @(negedge clk);
            check_value("dec_ready", 32'(dec_ready), 32'd0); // Not yet accepted
            @(posedge clk);
            fet_ready <= 1'b0;
            @(negedge clk);
            check_record(i);
        end

        // Back-pressure with random full signals
        idx          = 0;
        pending      = -1;
        stall_cycles = 0;
        prev_stall   = 1'b0;
        prev_dec     = '0;
        @(posedge clk);
        drive_vector(0);
        drive_random_full();
        while (idx < num_vec || pending >= 0) begin
            @(negedge clk);
            if (pending >= 0) begin
                check_record(pending);
            end else if (prev_stall) begin
                check_value("dec_ready", 32'(dec_ready), 32'd1);
                check_value("dec.op", 32'(dec.op), 32'(prev_dec.op));
                check_value("dec.imm", dec.imm, prev_dec.imm);
                check_value("dec.inst_addr", dec.inst_addr, prev_dec.inst_addr);
            end
            check_value("stall", 32'(stall),
                        32'(dec_ready && expected_stall(dec.op, rob_full, lsb_full, rs_full)));
            accepted_now = fet_ready && !stall;
            stall_cycles = stall ? stall_cycles + 1 : 0;
            if (stall_cycles > WAIT_LIMIT) begin
                fail_timeout("waiting for stall to drop");
            end
            prev_stall = stall;
            prev_dec   = dec;
            @(posedge clk);
            if (accepted_now) begin
                pending = idx;
                idx++;
                if (idx < num_vec) begin
                    drive_vector(idx);
                end else begin
                    fet_ready <= 1'b0;
                end
            end else begin
                pending = -1;
            end
            drive_random_full();
        end

        // Flush with a new instruction on offer
        rob_full <= 1'b0;
        lsb_full <= 1'b0;
        rs_full  <= 1'b0;
        drive_vector(0);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_record(0);
        @(negedge clk);
        check_value("dec_ready", 32'(dec_ready), 32'd0);
        @(posedge clk);
        flush <= 1'b0;

        // Flush while the held instruction stalls
        @(posedge clk);
        rob_full <= 1'b1; // Record arrives at this edge
        @(negedge clk);
        check_value("stall", 32'(stall), 32'd1);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_value("dec_ready", 32'(dec_ready), 32'd1); // Held until the flush edge
        check_value("stall", 32'(stall), 32'd1);
        @(negedge clk);
        check_value("dec_ready", 32'(dec_ready), 32'd0);
        check_value("stall", 32'(stall), 32'd0);
        @(posedge clk);
        flush     <= 1'b0;
        rob_full  <= 1'b0;
        fet_ready <= 1'b0;
        @(posedge clk);
        @(negedge clk);

        if (DUT.u_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* dv/decode_stimulus.txt */
# inst addr jump_pred | expected op rd rs1 rs2 imm c_extension
# all columns hex, op numbers follow inst_op_t
123452B7 00001000 0 01 05 00 00 12345000 0
FFFFF517 00001004 1 02 0A 00 00 FFFFF000 0
008000EF 00001008 0 03 01 00 00 00000008 0
FFDFF06F 0000100C 1 03 00 00 00 FFFFFFFC 0
0010016F 00001010 0 03 02 00 00 00000800 0
0000106F 00001014 0 03 00 00 00 00001000 0
010100E7 00001018 1 04 01 02 00 00000010 0
010110E7 0000101C 0 00 00 00 00 00000000 0
00208863 00001020 1 05 00 01 02 00000010 0
FE419FE3 00001024 0 06 00 03 04 FFFFFFFE 0
0062C0E3 00001028 1 07 00 05 06 00000800 0
0020D863 0000102C 0 08 00 01 02 00000010 0
0020E863 00001030 0 09 00 01 02 00000010 0
0020F863 00001034 1 0A 00 01 02 00000010 0
0020A863 00001038 0 00 00 00 00 00000000 0
00010083 0000103C 0 0B 01 02 00 00000000 0
00011083 00001040 0 0C 01 02 00 00000000 0
FFC42383 00001044 1 0D 07 08 00 FFFFFFFC 0
00014083 00001048 0 0E 01 02 00 00000000 0
00015083 0000104C 0 0F 01 02 00 00000000 0
00013083 00001050 0 00 00 00 00 00000000 0
FE320FA3 00001054 0 10 00 04 03 FFFFFFFF 0
00209423 00001058 1 11 00 01 02 00000008 0
0020A423 0000105C 0 12 00 01 02 00000008 0
0020B423 00001060 0 00 00 00 00 00000000 0
FFF10093 00001064 0 13 01 02 00 FFFFFFFF 0
00512093 00001068 0 14 01 02 00 00000005 0
00513093 0000106C 1 15 01 02 00 00000005 0
00514093 00001070 0 16 01 02 00 00000005 0
00516093 00001074 0 17 01 02 00 00000005 0
00517093 00001078 0 18 01 02 00 00000005 0
00311093 0000107C 0 19 01 02 00 00000003 0
01F15093 00001080 1 1A 01 02 00 0000001F 0
40715093 00001084 0 1B 01 02 00 00000007 0
002081B3 00001088 0 1C 03 01 02 00000000 0
402081B3 0000108C 0 1D 03 01 02 00000000 0
002091B3 00001090 0 1E 03 01 02 00000000 0
0020A1B3 00001094 1 1F 03 01 02 00000000 0
0020B1B3 00001098 0 20 03 01 02 00000000 0
0020C1B3 0000109C 0 21 03 01 02 00000000 0
0020D1B3 000010A0 0 22 03 01 02 00000000 0
4020D1B3 000010A4 1 23 03 01 02 00000000 0
0020E1B3 000010A8 0 24 03 01 02 00000000 0
0020F1B3 000010AC 0 25 03 01 02 00000000 0
0000000F 000010B0 0 00 00 00 00 00000000 0
00000073 000010B4 0 00 00 00 00 00000000 0
00000040 00002000 0 13 08 02 00 00000004 1
00000000 00002002 0 00 00 00 00 00000000 1
00004144 00002004 1 0D 09 0A 00 00000004 1
0000C124 00002006 0 12 00 0A 09 00000040 1
000012FD 00002008 0 13 05 05 00 FFFFFFFF 1
0000431D 0000200A 0 13 06 00 00 00000007 1
00002009 0000200C 1 03 01 00 00 00000002 1
0000BFFD 0000200E 0 03 00 00 00 FFFFFFFE 1
0000A801 00002010 1 03 00 00 00 00000010 1
00006185 00002012 0 01 03 00 00 00001000 1
00006141 00002014 0 13 02 02 00 00000010 1
0000717D 00002016 0 13 02 02 00 FFFFFFF0 1
0000800D 00002018 0 1A 08 08 00 00000003 1
00008485 0000201A 0 1B 09 09 00 00000001 1
00009979 0000201C 0 18 0A 0A 00 FFFFFFFE 1
00008C05 0000201E 0 1D 08 08 09 00000000 1
00008C25 00002020 0 21 08 08 09 00000000 1
00008C45 00002022 0 24 08 08 09 00000000 1
00008C65 00002024 0 25 08 08 09 00000000 1
00009C05 00002026 0 00 00 00 00 00000000 1
0000C401 00002028 1 05 00 08 00 00000008 1
0000FCFD 0000202A 0 06 00 09 00 FFFFFFFE 1
00000292 0000202C 0 19 05 05 00 00000004 1
000040B2 0000202E 0 0D 01 02 00 0000000C 1
00008082 00002030 1 04 00 01 00 00000000 1
00009282 00002032 0 04 01 05 00 00000000 1
00008192 00002034 0 1C 03 00 04 00000000 1
00009192 00002036 0 1C 03 03 04 00000000 1
00008002 00002038 0 00 00 00 00 00000000 1
0000C41A 0000203A 0 12 00 02 06 00000008 1
00002000 0000203C 0 00 00 00 00 00000000 1

/* files.f */
source/rv_decode_pkg.sv
source/rv32_base_decoder.sv
source/rvc_decoder.sv
source/decode_stage.sv
dv/decode_stage_checker.sv
dv/decode_stage_tb.sv

/* Bender.yml */
package:
  name: rv_decode_stage

sources:
  - source/rv_decode_pkg.sv
  - source/rv32_base_decoder.sv
  - source/rvc_decoder.sv
  - source/decode_stage.sv
  - target: test
    files:
      - dv/decode_stage_checker.sv
      - dv/decode_stage_tb.sv
